// File: flist.f
hdl/tfp_pkg.sv
hdl/smp_bus_if.sv
hdl/tfp2fix.sv
hdl/smp_ram.sv
hdl/smp_arbiter.sv
hdl/tfp_channel.sv
hdl/tfp_apb_regs.sv
hdl/tfp_accel_top.sv
bench/tfp_accel_props.sv
bench/tb_tfp_accel.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the accelerator testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_tfp_accel -f flist.f -o sim_tfp_accel

out=$(./obj_dir/sim_tfp_accel)
echo "$out"

if grep -qx "TEST PASSED" <<< "$out"; then
    exit 0
else
    exit 1
fi

// File: bench/tb_tfp_accel.sv
// Self-checking testbench for the accelerator, loads samples over APB and checks channel sums
`timescale 1ns/1ps

module tb_tfp_accel import tfp_pkg::*; ();

    localparam int N_TESTS     = 20;   // Tests with margin
    localparam int POLL_MAX    = 250;  // CTRL reads allowed per run
    localparam int POLL_NS     = 40;   // One poll plus slack
    localparam int WATCHDOG_NS = N_TESTS * POLL_MAX * POLL_NS; // 200 us

    logic              rst;     // Clock
    logic              clk;     // Reset, active high
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [APB_AW-1:0] paddr;
    logic [APB_DW-1:0] pwdata;
    logic [APB_DW-1:0] prdata;
    logic              pready;
    logic              pslverr;

    logic [TFP_W-1:0]  img [MEM_DEPTH]; // Copy of sample memory
    integer            seed;
    int                err_cnt = 0;     // Value mismatches
    int                fail_cnt = 0;    // Runs that never finished
    int                chk_cnt = 0;
    logic [31:0]       got_q [$];       // Pending compares
    logic [31:0]       exp_q [$];
    string             msg_q [$];
    logic [31:0]       rd_data;         // Last APB read
    logic              rd_err;          // Last pslverr

    tfp_accel_top dut0 (.rst, .clk, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata,
                        .pready, .pslverr);

    always #4 rst = ~rst;

    // Mantissa extended, shifted by the exponent, summed modulo 2**24
    function automatic logic [ACC_W-1:0] ref_sum(input logic [TFP_W-1:0] mem [MEM_DEPTH],
                                                 input int base, input int cnt, input bit sgn);
        logic [ACC_W-1:0] sum;
        logic [TFP_W-1:0] s;
        logic [ACC_W-1:0] v;
        sum = '0;
        for (int i = 0; i < cnt; i++) begin
            s = mem[(base + i) % MEM_DEPTH];   // Window wraps
            v = sgn ? {{19{s[7]}}, s[7:3]} : {19'b0, s[7:3]};
            sum = sum + (v << s[2:0]);
        end
        return sum;
    endfunction

    function automatic logic [APB_AW-1:0] ch_addr(input int ch, input int off);
        return APB_AW'(CH_BASE + ch * CH_STRIDE + off);
    endfunction

    // Compare process, drains what the sequence queued
    always @(negedge rst) begin
        while (got_q.size() > 0) begin
            chk_cnt++;
            if (got_q[0] !== exp_q[0]) begin
                $display("Error at %0d ns: %s, got %h expected %h", $time, msg_q[0],
                         got_q[0], exp_q[0]);
                err_cnt++;
            end
            void'(got_q.pop_front());
            void'(exp_q.pop_front());
            void'(msg_q.pop_front());
        end
    end

    task automatic expect_value(input logic [31:0] got, input logic [31:0] exp, input string msg);
        got_q.push_back(got);
        exp_q.push_back(exp);
        msg_q.push_back(msg);
    endtask

    // Setup on one falling edge, access on the next
    task automatic apb_access(input logic wr, input logic [APB_AW-1:0] addr,
                              input logic [31:0] data);
        @(negedge rst);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = data;
        @(negedge rst);
        penable = 1'b1;
        #2;                  // Mid low phase, outputs settled
        rd_data = prdata;
        rd_err  = pslverr;
        expect_value({31'b0, pready}, 32'h1, $sformatf("pready on access to %h", addr));
        @(negedge rst);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic load_image();
        for (int i = 0; i < MEM_DEPTH; i++)
            apb_access(1'b1, APB_AW'(i * 4), {24'b0, img[i]});
    endtask

    task automatic start_ch(input int ch, input int base, input int cnt);
        apb_access(1'b1, ch_addr(ch, REG_CFG), (cnt << CFG_CNT_LSB) | base);
        apb_access(1'b1, ch_addr(ch, REG_CTRL), 32'h1);
    endtask

    // Poll for done, then compare RESULT with the model
    task automatic check_ch(input int ch, input int base, input int cnt);
        int polls;
        polls = 0;
        do begin
            apb_access(1'b0, ch_addr(ch, REG_CTRL), '0);
            polls++;
        end while (!rd_data[1] && polls < POLL_MAX);
        if (!rd_data[1]) begin
            $display("Channel %0d never reported done after %0d status reads", ch, POLL_MAX);
            fail_cnt++;
        end
        apb_access(1'b0, ch_addr(ch, REG_RESULT), '0);
        expect_value(rd_data, {8'b0, ref_sum(img, base, cnt, ch == 0)},
                     $sformatf("ch%0d base %0d count %0d result", ch, base, cnt));
    endtask

    initial begin
        int b0;
        int b1;
        int c0;
        int c1;
        seed    = 32'h5808;
        rst     = 1'b0;
        clk     = 1'b1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        repeat (16) @(posedge rst);
        @(negedge rst);
        clk = 1'b0;

        for (int ch = 0; ch < N_CH; ch++) begin   // Idle status after reset
            apb_access(1'b0, ch_addr(ch, REG_CTRL), '0);
            expect_value(rd_data, 32'h0, $sformatf("ch%0d CTRL after reset", ch));
            apb_access(1'b0, ch_addr(ch, REG_RESULT), '0);
            expect_value(rd_data, 32'h0, $sformatf("ch%0d RESULT after reset", ch));
        end

        for (int i = 0; i < MEM_DEPTH; i++)
            img[i] = 8'(i * 37 + 11);             // Mixed signs across the window
        load_image();
        start_ch(0, 5, 40);
        check_ch(0, 5, 40);
        start_ch(1, 5, 40);
        check_ch(1, 5, 40);

        start_ch(0, 10, 50);                      // Overlapping windows, both busy
        start_ch(1, 30, 64);
        check_ch(0, 10, 50);
        check_ch(1, 30, 64);

        apb_access(1'b1, ch_addr(1, REG_CFG), 32'h0000_352A);
        apb_access(1'b0, ch_addr(1, REG_CFG), '0);
        expect_value(rd_data, 32'h0000_352A, "ch1 CFG readback");
        apb_access(1'b0, 12'h120, '0);            // Past the channel blocks
        expect_value({31'b0, rd_err}, 32'h1, "pslverr on unmapped read");
        apb_access(1'b1, 12'h10C, '0);            // Hole inside a block
        expect_value({31'b0, rd_err}, 32'h1, "pslverr on unmapped write");
        apb_access(1'b0, ch_addr(0, REG_RESULT), '0);
        expect_value({31'b0, rd_err}, 32'h0, "pslverr on mapped read");

        start_ch(0, 0, 64);                       // Restart with new CFG must be ignored
        apb_access(1'b1, ch_addr(0, REG_CFG), (7 << CFG_CNT_LSB) | 3);
        apb_access(1'b1, ch_addr(0, REG_CTRL), 32'h1);
        check_ch(0, 0, 64);

        for (int t = 0; t < 10; t++) begin
            for (int i = 0; i < MEM_DEPTH; i++)
                img[i] = 8'($random(seed));
            load_image();
            b0 = $random(seed) & 63;
            c0 = ($random(seed) & 63) + 1;
            b1 = $random(seed) & 63;
            c1 = ($random(seed) & 63) + 1;
            if (t == 0)
                c0 = 64;                          // Whole memory
            if (t == 1) begin
                b1 = 60;                          // Wraps past the top
                c1 = 20;
            end
            start_ch(0, b0, c0);
            start_ch(1, b1, c1);
            check_ch(0, b0, c0);
            check_ch(1, b1, c1);
        end

        repeat (4) @(negedge rst);                // Compare queue drains
        $display("Checks: %0d, value errors: %0d, other failures: %0d",
                 chk_cnt, err_cnt, fail_cnt);
        if (err_cnt == 0 && fail_cnt == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

    // Watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("Simulation still running after %0d ns, stopped by the watchdog", WATCHDOG_NS);
        $display("TEST FAILED");
        $finish;
    end

endmodule : tb_tfp_accel

// File: bench/tfp_accel_props.sv
// Arbiter protocol checks, bound into smp_arbiter and reported through failing assertions
`timescale 1ns/1ps

module tfp_accel_props import tfp_pkg::*; (
    input logic              rst,    // Clock
    input logic              clk,    // Async reset
    input logic              req0,
    input logic              req1,
    input logic [ADDR_W-1:0] addr0,
    input logic [ADDR_W-1:0] addr1,
    input logic              gnt0,
    input logic              gnt1,
    input logic              rv0,
    input logic              rv1
);

    // At most one winner per cycle
    a_gnt_onehot: assert property (@(posedge rst) disable iff (clk) $onehot0({gnt1, gnt0}))
        else $error("Both clients granted in the same cycle");

    // No grant without a request
    a_gnt_req: assert property (@(posedge rst) disable iff (clk)
        (!gnt0 || req0) && (!gnt1 || req1))
        else $error("Grant given to a client that is not requesting");

    // Read return exactly one cycle after the grant
    a_rv_delay: assert property (@(posedge rst) disable iff (clk)
        {rv1, rv0} == $past({gnt1, gnt0}))
        else $error("Read valid does not follow its grant by one cycle");

    // Stalled clients hold request and address
    a_hold0: assert property (@(posedge rst) disable iff (clk)
        (req0 && !gnt0) |=> (req0 && $stable(addr0)))
        else $error("Client 0 changed its stalled request");

    a_hold1: assert property (@(posedge rst) disable iff (clk)
        (req1 && !gnt1) |=> (req1 && $stable(addr1)))
        else $error("Client 1 changed its stalled request");

endmodule : tfp_accel_props

bind smp_arbiter tfp_accel_props u_props (
    .rst   (rst),
    .clk   (clk),
    .req0  (cl0.req),
    .req1  (cl1.req),
    .addr0 (cl0.addr),
    .addr1 (cl1.addr),
    .gnt0  (gnt0),
    .gnt1  (gnt1),
    .rv0   (rv0),
    .rv1   (rv1)
);

// File: hdl/tfp_accel_top.sv
// Top of the sample accelerator, APB pins in, registers, memory, arbiter and two channels inside
`timescale 1ns/1ps

module tfp_accel_top import tfp_pkg::*; (
    input  logic              rst,     // Clock
    input  logic              clk,     // Async reset, active high
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  logic [APB_AW-1:0] paddr,
    input  logic [APB_DW-1:0] pwdata,
    output logic [APB_DW-1:0] prdata,
    output logic              pready,
    output logic              pslverr
);

    logic                        mem_wen;
    logic [ADDR_W-1:0]           mem_waddr;
    tfp_word_u                   mem_wdata;
    logic                        ren;
    logic [ADDR_W-1:0]           raddr;
    logic [TFP_W-1:0]            rdata;
    logic [N_CH-1:0]             start;
    logic [N_CH-1:0][ADDR_W-1:0] base;
    logic [N_CH-1:0][CNT_W-1:0]  count;
    logic [N_CH-1:0]             busy;
    logic [N_CH-1:0]             done;
    logic [N_CH-1:0][ACC_W-1:0]  result;

    smp_bus_if bus0 ();    // Channel 0 read path
    smp_bus_if bus1 ();

    tfp_apb_regs u_regs (
        .rst, .clk, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready, .pslverr,
        .mem_wen, .mem_waddr, .mem_wdata, .start, .base, .count, .busy, .done, .result
    );

    smp_ram u_ram (.rst, .clk, .wen(mem_wen), .waddr(mem_waddr), .wdata(mem_wdata),
                   .ren, .raddr, .rdata);

    smp_arbiter u_arb (.rst, .clk, .cl0(bus0), .cl1(bus1), .ren, .raddr, .rdata);

    tfp_channel #(.SIGNREP("SIGNED")) u_ch0 (    // Signed mantissa
        .rst, .clk, .bus(bus0), .start(start[0]), .base(base[0]), .count(count[0]),
        .busy(busy[0]), .done(done[0]), .result(result[0])
    );

    tfp_channel #(.SIGNREP("UNSIGNED")) u_ch1 (  // Unsigned mantissa
        .rst, .clk, .bus(bus1), .start(start[1]), .base(base[1]), .count(count[1]),
        .busy(busy[1]), .done(done[1]), .result(result[1])
    );

endmodule : tfp_accel_top

// File: hdl/tfp_apb_regs.sv
// APB slave for sample writes, channel configuration, start pulses and status readback
`timescale 1ns/1ps

module tfp_apb_regs import tfp_pkg::*; (
    input  logic                        rst,       // Clock
    input  logic                        clk,       // Async reset
    input  logic                        psel,
    input  logic                        penable,
    input  logic                        pwrite,
    input  logic [APB_AW-1:0]           paddr,
    input  logic [APB_DW-1:0]           pwdata,
    output logic [APB_DW-1:0]           prdata,
    output logic                        pready,
    output logic                        pslverr,
    output logic                        mem_wen,
    output logic [ADDR_W-1:0]           mem_waddr,
    output tfp_word_u                   mem_wdata,
    output logic [N_CH-1:0]             start,
    output logic [N_CH-1:0][ADDR_W-1:0] base,
    output logic [N_CH-1:0][CNT_W-1:0]  count,
    input  logic [N_CH-1:0]             busy,
    input  logic [N_CH-1:0]             done,
    input  logic [N_CH-1:0][ACC_W-1:0]  result
);

    localparam int unsigned CH_TOP = CH_BASE + N_CH * CH_STRIDE; // End of channel blocks
    localparam int unsigned OFF_W  = $clog2(CH_STRIDE);
    localparam int unsigned IDX_W  = $clog2(N_CH);

    logic              access;  // Access phase
    logic              wr;
    logic              ram_hit;
    logic              reg_ok;  // Offset is a real register
    logic              ch_hit;
    logic [APB_AW-1:0] ch_off;  // Offset from channel 0 block
    logic [OFF_W-1:0]  reg_off;
    logic [IDX_W-1:0]  ch_idx;

    logic [N_CH-1:0][ADDR_W-1:0] cfg_base;
    logic [N_CH-1:0][CNT_W-1:0]  cfg_count;

    assign access = psel & penable;
    assign wr     = access & pwrite;

    // Address decode
    assign ch_off  = paddr - APB_AW'(CH_BASE);
    assign reg_off = ch_off[OFF_W-1:0];
    assign ch_idx  = ch_off[OFF_W +: IDX_W];
    assign ram_hit = (paddr < RAM_TOP);
    assign reg_ok  = (reg_off == REG_CFG) || (reg_off == REG_CTRL) || (reg_off == REG_RESULT);
    assign ch_hit  = (paddr >= CH_BASE) && (paddr < CH_TOP) && reg_ok;

    assign pready  = 1'b1;                       // No wait states
    assign pslverr = access & ~(ram_hit | ch_hit);

    // Sample memory write port
    assign mem_wen       = wr & ram_hit;
    assign mem_waddr     = paddr[ADDR_W+1:2];    // Word index
    assign mem_wdata.raw = pwdata[TFP_W-1:0];

    // CFG storage
    always_ff @(posedge rst or posedge clk) begin
        if (clk) begin
            cfg_base  <= '0;
            cfg_count <= '0;
        end else if (wr && ch_hit && (reg_off == REG_CFG)) begin
            cfg_base[ch_idx]  <= pwdata[ADDR_W-1:0];
            cfg_count[ch_idx] <= pwdata[CFG_CNT_LSB +: CNT_W];
        end
    end

    assign base  = cfg_base;
    assign count = cfg_count;

    // Start pulse lasts the access cycle
    always_comb begin
        start = '0;
        if (wr && ch_hit && (reg_off == REG_CTRL))
            start[ch_idx] = pwdata[0];
    end

    // Read mux
    always_comb begin
        prdata = '0;
        if (access && !pwrite && ch_hit) begin
            case (reg_off)
                OFF_W'(REG_CFG): begin
                    prdata[ADDR_W-1:0]           = cfg_base[ch_idx];
                    prdata[CFG_CNT_LSB +: CNT_W] = cfg_count[ch_idx];
                end
                OFF_W'(REG_CTRL): begin
                    prdata[0] = busy[ch_idx];
                    prdata[1] = done[ch_idx];
                end
                OFF_W'(REG_RESULT): prdata[ACC_W-1:0] = result[ch_idx]; // Zero-extended
                default: prdata = '0;
            endcase
        end
    end

endmodule : tfp_apb_regs

// File: hdl/tfp_channel.sv
// Channel engine that reads a sample window, converts every word and sums the fixed point values
`timescale 1ns/1ps

module tfp_channel import tfp_pkg::*; #(
    parameter SIGNREP = "SIGNED"      // Mantissa sign mode for the converter
) (
    input  logic              rst,    // Clock
    input  logic              clk,    // Async reset
    smp_bus_if.client         bus,
    input  logic              start,  // One-cycle pulse from APB
    input  logic [ADDR_W-1:0] base,
    input  logic [CNT_W-1:0]  count,
    output logic              busy,
    output logic              done,
    output logic [ACC_W-1:0]  result
);

    localparam bit IS_SIGNED = (SIGNREP == "SIGNED");

    logic              launch;     // Start accepted
    logic              accept;     // Read handed to memory
    logic              finish;     // Nothing left to issue or return
    logic [CNT_W-1:0]  issue_left; // Reads still to request
    logic [CNT_W-1:0]  in_flight;  // Issued but not yet summed
    logic [ADDR_W-1:0] addr_q;
    logic              conv_vld;   // Converter output is fresh
    tfp_word_u         smp;
    logic [FIX_W-1:0]  fix_val;
    logic [ACC_W-1:0]  fix_ext;
    logic [ACC_W-1:0]  acc;

    assign launch = start & ~busy;         // Ignored while running
    assign bus.req  = busy && (issue_left != '0);
    assign bus.addr = addr_q;
    assign accept   = bus.req & bus.gnt;
    assign finish   = busy && (issue_left == '0) && (in_flight == '0);

    // Busy and done status
    always_ff @(posedge rst or posedge clk) begin
        if (clk) begin
            busy <= 1'b0;
            done <= 1'b0;
        end else if (launch) begin
            busy <= 1'b1;
            done <= 1'b0;     // Cleared by a new run
        end else if (finish) begin
            busy <= 1'b0;
            done <= 1'b1;
        end
    end

    // Issue counter and address generator
    always_ff @(posedge rst or posedge clk) begin
        if (clk) begin
            issue_left <= '0;
            addr_q     <= '0;
        end else if (launch) begin
            issue_left <= count;
            addr_q     <= base;
        end else if (accept) begin
            issue_left <= issue_left - 1'b1;
            addr_q     <= addr_q + 1'b1; // Wraps at the top of memory
        end
    end

    // Reads outstanding
    always_ff @(posedge rst or posedge clk) begin
        if (clk)
            in_flight <= '0;
        else
            in_flight <= in_flight + CNT_W'(accept) - CNT_W'(conv_vld);
    end

    // Converter sees the field layout
    assign smp.raw = bus.rdata;

    tfp2fix #(
        .TFP_WIDTH (TFP_W),
        .EXP_WIDTH (EXP_W),
        .SIGNREP   (SIGNREP),
        .PIPELINE  (1)
    ) u_conv (
        .rst      (rst),
        .clk      (clk),
        .clkena   (bus.rvalid),     // Loads only on returned data
        .tfp_data ({smp.f.mant, smp.f.exp}),
        .fix_data (fix_val)
    );

    // Matches the converter register stage
    always_ff @(posedge rst or posedge clk) begin
        if (clk)
            conv_vld <= 1'b0;
        else
            conv_vld <= bus.rvalid;
    end

    // Widen to the sum width
    assign fix_ext = IS_SIGNED ? {{(ACC_W-FIX_W){fix_val[FIX_W-1]}}, fix_val}
                               : {{(ACC_W-FIX_W){1'b0}}, fix_val};

    // Accumulator
    always_ff @(posedge rst or posedge clk) begin
        if (clk)
            acc <= '0;
        else if (launch)
            acc <= '0;
        else if (conv_vld)
            acc <= acc + fix_ext; // Modulo 2**24
    end

    assign result = acc;

endmodule : tfp_channel

// File: hdl/smp_arbiter.sv
// Round-robin sharing of the single memory read port between the two channel engines
`timescale 1ns/1ps

module smp_arbiter import tfp_pkg::*; (
    input  logic              rst,   // Clock
    input  logic              clk,   // Async reset
    smp_bus_if.arbiter        cl0,
    smp_bus_if.arbiter        cl1,
    output logic              ren,   // Memory read strobe
    output logic [ADDR_W-1:0] raddr,
    input  logic [TFP_W-1:0]  rdata
);

    logic prio;   // Low gives client 0 first claim
    logic gnt0;
    logic gnt1;
    logic rv0;    // Client 0 read returns
    logic rv1;

    // Winner of this cycle
    always_comb begin
        gnt0 = cl0.req & (~cl1.req | ~prio);
        gnt1 = cl1.req & (~cl0.req | prio);
    end

    assign cl0.gnt = gnt0;
    assign cl1.gnt = gnt1;

    // Memory read port
    assign ren   = gnt0 | gnt1;
    assign raddr = gnt1 ? cl1.addr : cl0.addr;

    // Turn priority after every grant
    always_ff @(posedge rst or posedge clk) begin
        if (clk)
            prio <= 1'b0;
        else if (gnt0)
            prio <= 1'b1; // Client 1 next
        else if (gnt1)
            prio <= 1'b0;
    end

    // Remember the winner for the return cycle
    always_ff @(posedge rst or posedge clk) begin
        if (clk) begin
            rv0 <= 1'b0;
            rv1 <= 1'b0;
        end else begin
            rv0 <= gnt0;
            rv1 <= gnt1;
        end
    end

    assign cl0.rvalid = rv0;
    assign cl1.rvalid = rv1;

    // Data goes to both, rvalid tells whose it is
    assign cl0.rdata = rdata;
    assign cl1.rdata = rdata;

endmodule : smp_arbiter

// File: hdl/smp_ram.sv
// Sample memory, written by the APB side and read by the channel arbiter one edge after ren
`timescale 1ns/1ps

module smp_ram import tfp_pkg::*; (
    input  logic              rst,   // Clock
    input  logic              clk,   // Async reset
    input  logic              wen,
    input  logic [ADDR_W-1:0] waddr,
    input  tfp_word_u         wdata, // Raw byte from APB
    input  logic              ren,
    input  logic [ADDR_W-1:0] raddr,
    output logic [TFP_W-1:0]  rdata
);

    tfp_word_u mem [MEM_DEPTH]; // Sample store

    // Write port
    always_ff @(posedge rst) begin
        if (wen)
            mem[waddr] <= wdata;
    end

    // Read port, one edge of latency
    always_ff @(posedge rst or posedge clk) begin
        if (clk)
            rdata <= '0;
        else if (ren)
            rdata <= mem[raddr].raw; // Held between reads
    end

endmodule : smp_ram

// File: hdl/tfp2fix.sv
// Trivial float to fixed point converter with selectable mantissa sign and clock-enabled pipe
`timescale 1ns/1ps

module tfp2fix #(
    parameter int unsigned   TFP_WIDTH  = 8,        // Whole float word
    parameter int unsigned   EXP_WIDTH  = 3,        // Exponent in the low bits
    parameter                SIGNREP    = "SIGNED", // "SIGNED" or "UNSIGNED"
    parameter int unsigned   PIPELINE   = 1,        // Register stages
    localparam int unsigned  MANT_WIDTH = TFP_WIDTH - EXP_WIDTH,
    localparam int unsigned  FIX_WIDTH  = MANT_WIDTH + 2**EXP_WIDTH - 1
) (
    input  logic                 rst,      // Clock
    input  logic                 clk,      // Async reset, active high
    input  logic                 clkena,   // Advances the pipe
    input  logic [TFP_WIDTH-1:0] tfp_data,
    output logic [FIX_WIDTH-1:0] fix_data
);

    logic [FIX_WIDTH-1:0] mant_ext; // Mantissa widened to output size
    logic [EXP_WIDTH-1:0] shift;
    logic [FIX_WIDTH-1:0] fix_comb;

    // Widen mantissa by sign or zero
    generate
        if (SIGNREP == "SIGNED") begin : g_sext
            assign mant_ext = {{(FIX_WIDTH-MANT_WIDTH){tfp_data[TFP_WIDTH-1]}},
                               tfp_data[TFP_WIDTH-1:EXP_WIDTH]};
        end else begin : g_zext
            assign mant_ext = {{(FIX_WIDTH-MANT_WIDTH){1'b0}}, tfp_data[TFP_WIDTH-1:EXP_WIDTH]};
        end
    endgenerate

    assign shift    = tfp_data[EXP_WIDTH-1:0];
    assign fix_comb = mant_ext << shift; // Exponent is a plain left shift

    generate
        if (PIPELINE > 0) begin : g_pipe
            logic [FIX_WIDTH-1:0] stage [PIPELINE]; // stage[0] nearest the input

            always_ff @(posedge rst or posedge clk) begin
                if (clk) begin
                    for (int i = 0; i < PIPELINE; i++)
                        stage[i] <= '0;
                end else if (clkena) begin
                    stage[0] <= fix_comb;
                    for (int i = 1; i < PIPELINE; i++)
                        stage[i] <= stage[i-1]; // Shift whole chain together
                end
            end

            assign fix_data = stage[PIPELINE-1];
        end else begin : g_comb
            assign fix_data = fix_comb; // No latency
        end
    endgenerate

endmodule : tfp2fix

// File: hdl/smp_bus_if.sv
// Read path of one channel into the shared sample memory, client side and arbiter side
`timescale 1ns/1ps

interface smp_bus_if import tfp_pkg::*; ();

    logic              req;    // Channel wants a read
    logic [ADDR_W-1:0] addr;   // Held while not granted
    logic              gnt;    // Accepted this cycle
    logic              rvalid; // Data of last grant
    logic [TFP_W-1:0]  rdata;  // Shared by both clients

    modport client (
        output req,
        output addr,
        input  gnt,
        input  rvalid,
        input  rdata
    );

    modport arbiter (
        input  req,
        input  addr,
        output gnt,
        output rvalid,
        output rdata
    );

endinterface : smp_bus_if

// File: hdl/tfp_pkg.sv
// Shared widths, register map and sample word layout, imported by every accelerator block
package tfp_pkg;

    // Sample format
    localparam int unsigned TFP_W  = 8;             // Raw sample width
    localparam int unsigned EXP_W  = 3;             // Exponent field
    localparam int unsigned MANT_W = TFP_W - EXP_W; // Mantissa field
    localparam int unsigned FIX_W  = 12;            // Mantissa plus largest shift of 7
    localparam int unsigned ACC_W  = 24;            // Channel sum width

    // Sample memory
    localparam int unsigned MEM_DEPTH = 64;
    localparam int unsigned ADDR_W    = 6;
    localparam int unsigned CNT_W     = 7;          // Holds a full count of 64
    localparam int unsigned N_CH      = 2;

    // APB bus
    localparam int unsigned APB_AW = 12;
    localparam int unsigned APB_DW = 32;

    // Register offsets inside one channel block
    localparam int unsigned REG_CFG    = 'h0;
    localparam int unsigned REG_CTRL   = 'h4;
    localparam int unsigned REG_RESULT = 'h8;
    localparam int unsigned CFG_CNT_LSB = 8;        // Count field in CFG

    // Address map
    localparam int unsigned CH_BASE   = 'h100;      // Channel 0 block
    localparam int unsigned CH_STRIDE = 'h10;
    localparam int unsigned RAM_TOP   = 'h100;      // End of sample region

    // Sample word, raw from APB or split for the converter
    typedef union packed {
        logic [TFP_W-1:0] raw;
        struct packed {
            logic [MANT_W-1:0] mant; // Upper bits
            logic [EXP_W-1:0]  exp;  // Left shift amount
        } f;
    } tfp_word_u;

endpackage : tfp_pkg
